// ==== include/coreCfg_cfg.svh ====
`ifndef CORECFG_CFG_SVH
`define CORECFG_CFG_SVH

// data and address width
`define XLEN 32

// architectural register file
`define REG_COUNT 32
`define REG_IDX_W 5

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== runSim.sh ====
#!/bin/sh
# build and run the core testbench from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ps --top-module coreTb -f verilog.f -o coreSim \
	&& ./obj_dir/coreSim > sim.log 2>&1 \
	|| { echo "build or simulation error, see sim.log"; exit 1; }
grep -q "test passed" sim.log && ! grep -q "test failed" sim.log \
	&& echo "simulation PASS" \
	|| { echo "simulation FAIL, see sim.log"; exit 1; }

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu import rv32Pkg::*; (
	input  aluOp_t aluOp,
	input  word_t  srcA,
	input  word_t  srcB,
	output word_t  result,
	output logic   zero
);

	logic [4:0] shamt;

	// shift amount is the low five bits only
	assign shamt = srcB[4:0];

	always_comb begin
		case (aluOp)
			aluAdd:   result = srcA + srcB;
			aluSub:   result = srcA - srcB;
			aluAnd:   result = srcA & srcB;
			aluOr:    result = srcA | srcB;
			aluXor:   result = srcA ^ srcB;
			aluSlt:   result = word_t'($signed(srcA) < $signed(srcB));
			aluSltu:  result = word_t'(srcA < srcB);
			aluSll:   result = srcA << shamt;
			aluSrl:   result = srcA >> shamt;
			aluSra:   result = $signed(srcA) >>> shamt;
			aluPassB: result = srcB;
			default:  result = '0;
		endcase
	end

	// beq and bne look at this after a sub
	assign zero = (result == '0);

endmodule

// ==== source/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit import rv32Pkg::*; (
	input  instr_t inst,
	output aluOp_t aluOp,
	output logic   aluSrcImm,
	output logic   memToReg,
	output logic   memWrite,
	output logic   memRead,
	output logic   regWrite,
	output logic   branch,
	output logic   branchOnNotZero,
	output logic   jump,
	output logic   linkPc,
	output logic   halt
);

	// funct3 to ALU operation, alt selects sub or sra
	function automatic aluOp_t decodeAlu(input logic [2:0] funct3, input logic alt);
		aluOp_t op;
		case (funct3)
			3'b000:  op = alt ? aluSub : aluAdd;
			3'b001:  op = aluSll;
			3'b010:  op = aluSlt;
			3'b011:  op = aluSltu;
			3'b100:  op = aluXor;
			3'b101:  op = alt ? aluSra : aluSrl;
			3'b110:  op = aluOr;
			default: op = aluAnd;
		endcase
		return op;
	endfunction

	logic isShift;

	// only slli, srli and srai carry funct7 in an immediate op
	assign isShift = (inst.rType.funct3[1:0] == 2'b01);

	always_comb begin
		aluOp = aluAdd;
		aluSrcImm = 1'b0;
		memToReg = 1'b0;
		memWrite = 1'b0;
		memRead = 1'b0;
		regWrite = 1'b0;
		branch = 1'b0;
		branchOnNotZero = 1'b0;
		jump = 1'b0;
		linkPc = 1'b0;
		halt = 1'b0;
		case (inst.rType.opcode)
			opOp: begin
				regWrite = 1'b1;
				aluOp = decodeAlu(inst.rType.funct3, inst.rType.funct7[5]);
			end
			opImm: begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				aluOp = decodeAlu(inst.rType.funct3, isShift && inst.rType.funct7[5]);
			end
			load: begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				memRead = 1'b1;
				memToReg = 1'b1;
			end
			store: begin
				aluSrcImm = 1'b1;
				memWrite = 1'b1;
			end
			rv32Pkg::branch: begin
				// beq and bne compare through a subtraction
				aluOp = aluSub;
				branch = (inst.rType.funct3[2:1] == 2'b00);
				branchOnNotZero = (inst.rType.funct3 == 3'b001);
			end
			jal: begin
				jump = 1'b1;
				linkPc = 1'b1;
				regWrite = 1'b1;
			end
			lui: begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				aluOp = aluPassB;
			end
			system: begin
				halt = (inst.iType.funct3 == 3'b000) && (inst.iType.imm12 == 12'h001);
			end
			default: begin
				// unknown opcode runs as a nop
			end
		endcase
	end

endmodule

// ==== source/immediateGen.sv ====
`timescale 1ns/1ps

module immediateGen import rv32Pkg::*; (
	input  instr_t inst,
	output word_t  imm
);

	logic [31:0] w;

	assign w = inst;

	always_comb begin
		case (inst.rType.opcode)
			opImm, load: begin
				imm = {{20{inst.iType.imm12[11]}}, inst.iType.imm12};
			end
			store: begin
				imm = {{20{w[31]}}, w[31:25], w[11:7]};
			end
			branch: begin
				// offsets are in half words, bit 0 always clear
				imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			end
			lui: begin
				imm = {w[31:12], 12'b0};
			end
			jal: begin
				imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			end
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

// ==== source/pcUnit.sv ====
`timescale 1ns/1ps
`include "coreCfg_cfg.svh"

module pcUnit import rv32Pkg::*; (
	input  logic  clk,
	input  logic  arstN,
	input  logic  branchTaken,
	input  logic  halt,
	input  word_t imm,
	output word_t pc
);

	word_t pcNext;

	always_comb begin
		if (halt) begin
			pcNext = pc;
		end else if (branchTaken) begin
			pcNext = pc + imm;
		end else begin
			pcNext = pc + 32'd4;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= `RESET_PC;
		end else begin
			pc <= pcNext;
		end
	end

	// targets from imm must keep word alignment
	assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00);

endmodule

// ==== source/registerFile.sv ====
`timescale 1ns/1ps
`include "coreCfg_cfg.svh"

module registerFile import rv32Pkg::*; (
	input  logic    clk,
	input  logic    arstN,
	input  regIdx_t rs1,
	input  regIdx_t rs2,
	input  regIdx_t rd,
	input  word_t   wdata,
	input  logic    regWrite,
	output word_t   rs1Data,
	output word_t   rs2Data
);

	word_t regs [`REG_COUNT];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite && (rd != '0)) begin
			// x0 never takes a write
			regs[rd] <= wdata;
		end
	end

	assign rs1Data = regs[rs1];
	assign rs2Data = regs[rs2];

	assert property (@(posedge clk) disable iff (!arstN)
		(rs1 == '0) |-> (rs1Data == '0));

	assert property (@(posedge clk) disable iff (!arstN)
		(rs2 == '0) |-> (rs2Data == '0));

endmodule

// ==== source/rv32Core.sv ====
`timescale 1ns/1ps

module rv32Core import rv32Pkg::*; (
	input  logic   clk,
	input  logic   arstN,
	output word_t  pc,
	input  instr_t inst,
	output word_t  dataAddr,
	output word_t  storeData,
	output logic   memWrite,
	output logic   memRead,
	input  word_t  loadData,
	output logic   halt
);

	aluOp_t aluOp;
	logic   aluSrcImm;
	logic   memToReg;
	logic   memWriteCtl;
	logic   regWriteCtl;
	logic   regWrite;
	logic   branch;
	logic   branchOnNotZero;
	logic   jump;
	logic   linkPc;
	logic   branchTaken;
	logic   zero;
	word_t  imm;
	word_t  rs1Data;
	word_t  rs2Data;
	word_t  srcB;
	word_t  aluResult;
	word_t  wdata;

	controlUnit control (
		.inst(inst),
		.aluOp(aluOp),
		.aluSrcImm(aluSrcImm),
		.memToReg(memToReg),
		.memWrite(memWriteCtl),
		.memRead(memRead),
		.regWrite(regWriteCtl),
		.branch(branch),
		.branchOnNotZero(branchOnNotZero),
		.jump(jump),
		.linkPc(linkPc),
		.halt(halt)
	);

	// nothing commits while halted
	assign regWrite = regWriteCtl & ~halt;
	assign memWrite = memWriteCtl & ~halt;

	registerFile regFile (
		.clk(clk),
		.arstN(arstN),
		.rs1(inst.rType.rs1),
		.rs2(inst.rType.rs2),
		.rd(inst.rType.rd),
		.wdata(wdata),
		.regWrite(regWrite),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data)
	);

	immediateGen immGen (
		.inst(inst),
		.imm(imm)
	);

	assign srcB = aluSrcImm ? imm : rs2Data;

	alu execUnit (
		.aluOp(aluOp),
		.srcA(rs1Data),
		.srcB(srcB),
		.result(aluResult),
		.zero(zero)
	);

	assign branchTaken = jump | (branch & (branchOnNotZero ? ~zero : zero));

	pcUnit pcReg (
		.clk(clk),
		.arstN(arstN),
		.branchTaken(branchTaken),
		.halt(halt),
		.imm(imm),
		.pc(pc)
	);

	// jal links the address after itself
	assign wdata = memToReg ? loadData : (linkPc ? pc + 32'd4 : aluResult);

	assign dataAddr = aluResult;
	assign storeData = rs2Data;

endmodule

// ==== source/rv32Pkg.sv ====
`include "coreCfg_cfg.svh"

package rv32Pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`REG_IDX_W-1:0] regIdx_t;

	// major opcodes, bits [6:0] of the instruction
	typedef enum logic [6:0] {
		opOp   = 7'b0110011,
		opImm  = 7'b0010011,
		load   = 7'b0000011,
		store  = 7'b0100011,
		branch = 7'b1100011,
		jal    = 7'b1101111,
		lui    = 7'b0110111,
		system = 7'b1110011
	} opcode_t;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluSra,
		aluPassB
	} aluOp_t;

	// same word seen as register form or immediate form
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			regIdx_t    rs2;
			regIdx_t    rs1;
			logic [2:0] funct3;
			regIdx_t    rd;
			opcode_t    opcode;
		} rType;
		struct packed {
			logic [11:0] imm12;
			regIdx_t     rs1;
			logic [2:0]  funct3;
			regIdx_t     rd;
			opcode_t     opcode;
		} iType;
	} instr_t;

endpackage

// ==== test/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
	output logic clk,
	output logic arstN
);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// reset over five rising edges, released on a falling edge
	initial begin
		arstN = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
	end

endmodule

// ==== test/corePatterns.txt ====
# P addr word = program word, D addr word = initial data word
# E name addr value = expected store in order, all numbers hex
P 00000000 10000093
P 00000004 FF900113
P 00000008 00300193
P 0000000C 40218233
P 00000010 0040A023
P 00000014 403152B3
P 00000018 0050A223
P 0000001C 00312333
P 00000020 0021B3B3
P 00000024 00431313
P 00000028 00736333
P 0000002C 0060A423
P 00000030 00315433
P 00000034 0F044413
P 00000038 0080A623
P 0000003C 1000A483
P 00000040 004484B3
P 00000044 4044D493
P 00000048 0090A823
P 0000004C 00500013
P 00000050 0000AA23
P 00000054 00310463
P 00000058 00311463
P 0000005C 0020AC23
P 00000060 00420463
P 00000064 0020AC23
P 00000068 0080056F
P 0000006C 0020AC23
P 00000070 00A0AC23
P 00000074 DEADC5B7
P 00000078 EEF58593
P 0000007C 00B0AE23
P 00000080 00100073
D 00000200 12345678
E subReg 00000100 0000000A
E sraNegative 00000104 FFFFFFFF
E sltSltuSlliOr 00000108 00000011
E srlXori 0000010C 1FFFFF0F
E loadAddSrai 00000110 01234568
E storeX0 00000114 00000000
E jalLink 00000118 0000006C
E luiAddi 0000011C DEADBEEF

// ==== test/coreTb.sv ====
`timescale 1ns/1ps
`include "coreCfg_cfg.svh"

module coreTb import rv32Pkg::*; ();

	localparam word_t NOP = 32'h0000_0013;
	localparam word_t EBREAK = 32'h0010_0073;
	localparam int WAIT_LIMIT = 200;

	logic   clk;
	logic   arstN;
	word_t  pc;
	instr_t inst;
	word_t  dataAddr;
	word_t  storeData;
	logic   memWrite;
	logic   memRead;
	word_t  loadData;
	logic   halt;

	word_t imem [256];
	word_t dmem [256];
	word_t stAddr [$];
	word_t stVal [$];
	string expName [$];
	word_t expAddr [$];
	word_t expVal [$];
	word_t haltAddr;
	bit    testOk;
	bit    aborted;
	int    passCount;
	int    failCount;

	clockGen clocks (.clk(clk), .arstN(arstN));

	rv32Core dut (
		.clk(clk),
		.arstN(arstN),
		.pc(pc),
		.inst(inst),
		.dataAddr(dataAddr),
		.storeData(storeData),
		.memWrite(memWrite),
		.memRead(memRead),
		.loadData(loadData),
		.halt(halt)
	);

	// nop while in reset so no store or halt shows up
	assign inst = arstN ? instr_t'(imem[pc[9:2]]) : instr_t'(NOP);
	assign loadData = memRead ? dmem[dataAddr[9:2]] : '0;

	always @(posedge clk) begin
		if (arstN && memWrite) begin
			dmem[dataAddr[9:2]] = storeData;
			stAddr.push_back(dataAddr);
			stVal.push_back(storeData);
		end
	end

	task automatic checkWord(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("mismatch %s expected %h actual %h", name, expected, actual);
			testOk = 1'b0;
		end
	endtask

	task automatic checkPc(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("mismatch %s expected %h actual %h", name, expected, actual);
			testOk = 1'b0;
		end
	endtask

	task automatic checkLevel(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("mismatch %s expected %b actual %b", name, expected, actual);
			testOk = 1'b0;
		end
	endtask

	task automatic finishTest(input string name);
		if (testOk) begin
			$display("ok %s", name);
			passCount++;
		end else begin
			failCount++;
		end
		testOk = 1'b1;
	endtask

	task automatic waitForStore(input int idx, output bit ok);
		int cycles;
		cycles = 0;
		while (stAddr.size() <= idx && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		ok = (stAddr.size() > idx);
	endtask

	task automatic waitForHalt(output bit ok);
		int cycles;
		cycles = 0;
		while (!halt && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		ok = halt;
	endtask

	task automatic loadPatterns();
		int fd;
		int n;
		logic [8*96-1:0] lineBuf;
		logic [7:0] tag;
		logic [8*24-1:0] nameBuf;
		word_t addr;
		word_t value;
		fd = $fopen("test/corePatterns.txt", "r");
		if (fd == 0) begin
			$display("cannot open the pattern file test/corePatterns.txt");
			failCount++;
			aborted = 1'b1;
		end else begin
			while (!$feof(fd)) begin
				lineBuf = '0;
				n = $fgets(lineBuf, fd);
				n = $sscanf(lineBuf, "%s %h %h", tag, addr, value);
				if (n == 3 && tag == "P") begin
					imem[addr[9:2]] = value;
					if (value == EBREAK) haltAddr = addr;
				end else if (n == 3 && tag == "D") begin
					dmem[addr[9:2]] = value;
				end else if (n >= 1 && tag == "E") begin
					n = $sscanf(lineBuf, "%s %s %h %h", tag, nameBuf, addr, value);
					expName.push_back(string'(nameBuf));
					expAddr.push_back(addr);
					expVal.push_back(value);
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin
		bit ok;
		int i;
		testOk = 1'b1;
		aborted = 1'b0;
		passCount = 0;
		failCount = 0;
		haltAddr = '0;
		void'($urandom(32'h83b6));
		for (i = 0; i < 256; i++) begin
			imem[i] = NOP;
			dmem[i] = $urandom;
		end
		loadPatterns();

		// sample just after each falling edge while reset is low
		for (i = 0; i < 20 && !arstN; i++) begin
			@(negedge clk);
			#1;
			if (i == 2) begin
				checkPc("pc in reset", `RESET_PC, pc);
				checkLevel("memWrite in reset", 1'b0, memWrite);
				checkLevel("halt in reset", 1'b0, halt);
				finishTest("resetHold");
			end
		end
		if (!arstN) begin
			$display("reset was never released");
			failCount++;
			aborted = 1'b1;
		end else begin
			checkPc("pc after reset", `RESET_PC, pc);
			checkLevel("memWrite after reset", 1'b0, memWrite);
			checkLevel("memRead after reset", 1'b0, memRead);
			checkLevel("halt after reset", 1'b0, halt);
			finishTest("resetRelease");
		end

		for (i = 0; i < expAddr.size() && !aborted; i++) begin
			waitForStore(i, ok);
			if (!ok) begin
				$display("core never stored %s within %0d cycles", expName[i], WAIT_LIMIT);
				failCount++;
				aborted = 1'b1;
			end else begin
				checkWord({expName[i], " address"}, expAddr[i], stAddr[i]);
				checkWord(expName[i], expVal[i], stVal[i]);
				finishTest(expName[i]);
			end
		end

		if (!aborted) begin
			waitForHalt(ok);
			if (!ok) begin
				$display("core never halted within %0d cycles", WAIT_LIMIT);
				failCount++;
			end else begin
				checkPc("pc at halt", haltAddr, pc);
				checkLevel("memRead at halt", 1'b0, memRead);
				repeat (10) @(negedge clk);
				checkPc("pc ten cycles after halt", haltAddr, pc);
				checkLevel("halt held", 1'b1, halt);
				checkWord("store count", word_t'(expAddr.size()), word_t'(stAddr.size()));
				finishTest("halt");
			end
		end

		$display("closing count: %0d passed, %0d failed", passCount, failCount);
		if (failCount == 0 && passCount > 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+include
source/rv32Pkg.sv
source/controlUnit.sv
source/registerFile.sv
source/immediateGen.sv
source/alu.sv
source/pcUnit.sv
source/rv32Core.sv
test/clockGen.sv
test/coreTb.sv
